// ==== riscv_trace_pkg.sv ====
// RISC-V hart trace definitions

package riscv_trace_pkg;

  // --------------------
  // architectural widths
  // --------------------

  // virtual address
  localparam int unsigned Vlen = 64;

  // integer register
  localparam int unsigned Xlen = 64;

  // uncompressed instruction word
  localparam int unsigned InsnWidth = 32;

  // msb of the cause register flags an interrupt
  localparam int unsigned IrqCauseBit = Xlen - 1;

  // --------------------
  // privilege levels
  // --------------------

  typedef enum logic [1:0] {
    PrivLvlU = 2'b00,
    PrivLvlS = 2'b01,
    PrivLvlM = 2'b11
  } priv_lvl_t;

endpackage

// ==== commit_trace_pkg.sv ====
// Commit trace configuration and records

package commit_trace_pkg;

  // --------------------
  // sizing
  // --------------------

  localparam int unsigned NrCommitPorts = 2;
  localparam int unsigned PcQueueDepth  = 16;
  localparam int unsigned PortIdxWidth  = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

  // queue pointer and fill count
  localparam int unsigned PcPtrWidth = $clog2(PcQueueDepth);
  localparam int unsigned PcCntWidth = $clog2(PcQueueDepth + 1);

  // --------------------
  // records
  // --------------------

  // instruction at the head of a commit port
  typedef struct packed {
    logic [riscv_trace_pkg::Vlen-1:0] pc;
    logic                             ex_valid;
    logic [riscv_trace_pkg::Xlen-1:0] cause;
    logic [riscv_trace_pkg::Xlen-1:0] tval;
  } commit_entry_t;

  // per-port trace record
  typedef struct packed {
    logic                                  valid;
    logic [riscv_trace_pkg::Vlen-1:0]      iaddr;
    logic [riscv_trace_pkg::InsnWidth-1:0] insn;
    riscv_trace_pkg::priv_lvl_t            priv;
    logic                                  exception;
    logic                                  interrupt;
    logic [riscv_trace_pkg::Xlen-1:0]      cause;
    logic [riscv_trace_pkg::InsnWidth-1:0] tval;
  } trace_port_t;

  // one entry of the merged retire stream
  typedef struct packed {
    logic [riscv_trace_pkg::Vlen-1:0] pc;
    logic [PortIdxWidth-1:0]          port;
  } retire_t;

endpackage

// ==== commit_trace_gen.sv ====
// Commit trace record generator
`timescale 1ns/10ps

module commit_trace_gen (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  logic [commit_trace_pkg::NrCommitPorts-1:0]                    commit_ack_i,
  input  commit_trace_pkg::commit_entry_t [commit_trace_pkg::NrCommitPorts-1:0] commit_instr_i,
  input  riscv_trace_pkg::priv_lvl_t                                    priv_lvl_i,
  output commit_trace_pkg::trace_port_t [commit_trace_pkg::NrCommitPorts-1:0] trace_o,
  output logic [commit_trace_pkg::NrCommitPorts-1:0]                    push_o,
  output logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::Vlen-1:0] push_pc_o
);

  // classification of the current commit
  logic [commit_trace_pkg::NrCommitPorts-1:0] is_valid, is_exc, is_irq;

  // registered record
  logic [commit_trace_pkg::NrCommitPorts-1:0] valid_q, exc_q, irq_q;
  logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::Vlen-1:0]      iaddr_q;
  logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::InsnWidth-1:0] insn_q;
  logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::Xlen-1:0]      cause_q;
  riscv_trace_pkg::priv_lvl_t priv_q;

  always_comb begin
    for (int i = 0; i < commit_trace_pkg::NrCommitPorts; i++) begin
      is_valid[i] = commit_ack_i[i] & ~commit_instr_i[i].ex_valid;
      // cause msb splits traps into interrupts and exceptions
      is_exc[i]   = commit_ack_i[i] & commit_instr_i[i].ex_valid &
                    ~commit_instr_i[i].cause[riscv_trace_pkg::IrqCauseBit];
      is_irq[i]   = commit_ack_i[i] & commit_instr_i[i].ex_valid &
                    commit_instr_i[i].cause[riscv_trace_pkg::IrqCauseBit];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      exc_q   <= '0;
      irq_q   <= '0;
    end else begin
      valid_q <= is_valid;
      exc_q   <= is_exc;
      irq_q   <= is_irq;
    end
  end

  // payload only follows acked commits
  always_ff @(posedge clk_i) begin
    priv_q <= priv_lvl_i;
    for (int i = 0; i < commit_trace_pkg::NrCommitPorts; i++) begin
      if (commit_ack_i[i]) begin
        iaddr_q[i] <= commit_instr_i[i].pc;
        insn_q[i]  <= commit_instr_i[i].tval[riscv_trace_pkg::InsnWidth-1:0];
        cause_q[i] <= commit_instr_i[i].cause;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < commit_trace_pkg::NrCommitPorts; i++) begin
      trace_o[i].valid     = valid_q[i];
      trace_o[i].iaddr     = iaddr_q[i];
      trace_o[i].insn      = insn_q[i];
      trace_o[i].priv      = priv_q;
      trace_o[i].exception = exc_q[i];
      trace_o[i].interrupt = irq_q[i];
      trace_o[i].cause     = cause_q[i];
      trace_o[i].tval      = insn_q[i];
    end
  end

  // normal retires feed the pc queues
  assign push_o    = valid_q;
  assign push_pc_o = iaddr_q;

  for (genvar i = 0; i < commit_trace_pkg::NrCommitPorts; i++) begin : gen_excl_check
    // an acked commit yields exactly one kind of record
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[i] |=> $onehot({trace_o[i].valid, trace_o[i].exception,
                                   trace_o[i].interrupt}));
  end

endmodule

// ==== pc_queue.sv ====
// Retired PC FIFO
`timescale 1ns/10ps

module pc_queue (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             push_i,
  input  logic [riscv_trace_pkg::Vlen-1:0] pc_i,
  input  logic                             pop_i,
  output logic                             empty_o,
  output logic [riscv_trace_pkg::Vlen-1:0] head_o,
  output logic                             overflow_o
);

  // --------------------
  // storage
  // --------------------

  logic [riscv_trace_pkg::Vlen-1:0] mem_q [commit_trace_pkg::PcQueueDepth];

  logic [commit_trace_pkg::PcPtrWidth-1:0] rd_ptr_q, wr_ptr_q;
  logic [commit_trace_pkg::PcCntWidth-1:0] count_q;
  logic                                    overflow_q;

  logic full;
  logic do_push, do_pop;

  assign full    = (count_q == commit_trace_pkg::PcCntWidth'(commit_trace_pkg::PcQueueDepth));
  assign empty_o = (count_q == '0);

  // a pop in the same cycle frees the slot a full queue needs
  assign do_push = push_i & (~full | pop_i);
  assign do_pop  = pop_i & ~empty_o;

  assign head_o     = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

  // --------------------
  // pointers and count
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      // sticky until reset, the pc is lost
      if (push_i && !do_push) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  // the arbiter must only pop a queue that reports data
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

// ==== pc_arbiter.sv ====
// Round-robin retired PC merge
`timescale 1ns/10ps

module pc_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [commit_trace_pkg::NrCommitPorts-1:0]             empty_i,
  input  logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::Vlen-1:0] head_i,
  output logic [commit_trace_pkg::NrCommitPorts-1:0]             pop_o,
  output logic                                                   retire_valid_o,
  output commit_trace_pkg::retire_t                              retire_o
);

  logic [commit_trace_pkg::PortIdxWidth-1:0] rr_q, rr_d;
  logic [commit_trace_pkg::PortIdxWidth-1:0] gnt_idx;
  logic                                      gnt_found;

  logic                      retire_valid_q;
  commit_trace_pkg::retire_t retire_q;

  // --------------------
  // grant search
  // --------------------

  // first non-empty queue at or after the pointer
  always_comb begin : p_grant
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int unsigned k = 0; k < commit_trace_pkg::NrCommitPorts; k++) begin
      cand = (int'(rr_q) + k) % commit_trace_pkg::NrCommitPorts;
      if (!gnt_found && !empty_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = commit_trace_pkg::PortIdxWidth'(cand);
      end
    end
  end

  always_comb begin
    pop_o = '0;
    if (gnt_found) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // next search starts after the granted port
  always_comb begin
    rr_d = rr_q;
    if (gnt_found) begin
      if (int'(gnt_idx) == commit_trace_pkg::NrCommitPorts - 1) begin
        rr_d = '0;
      end else begin
        rr_d = gnt_idx + 1'b1;
      end
    end
  end

  // --------------------
  // output register
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q           <= '0;
      retire_valid_q <= 1'b0;
    end else begin
      rr_q           <= rr_d;
      retire_valid_q <= gnt_found;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_found) begin
      retire_q.pc   <= head_i[gnt_idx];
      retire_q.port <= gnt_idx;
    end
  end

  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(pop_o));

  // a port is not granted twice in a row while another one waits
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|pop_o) && (|(~empty_i & ~pop_o)) |=> ((pop_o & $past(pop_o)) == '0));

endmodule

// ==== commit_trace_unit.sv ====
// Commit trace unit top level
`timescale 1ns/10ps

module commit_trace_unit (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  logic [commit_trace_pkg::NrCommitPorts-1:0]                    commit_ack_i,
  input  commit_trace_pkg::commit_entry_t [commit_trace_pkg::NrCommitPorts-1:0] commit_instr_i,
  input  riscv_trace_pkg::priv_lvl_t                                    priv_lvl_i,
  output commit_trace_pkg::trace_port_t [commit_trace_pkg::NrCommitPorts-1:0] trace_o,
  output logic                                                          retire_valid_o,
  output commit_trace_pkg::retire_t                                     retire_o,
  output logic                                                          overflow_o
);

  // --------------------
  // gen <-> queues
  // --------------------
  logic [commit_trace_pkg::NrCommitPorts-1:0]                           push;
  logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::Vlen-1:0] push_pc;

  // --------------------
  // queues <-> arbiter
  // --------------------
  logic [commit_trace_pkg::NrCommitPorts-1:0]                           pc_empty;
  logic [commit_trace_pkg::NrCommitPorts-1:0]                           pc_pop;
  logic [commit_trace_pkg::NrCommitPorts-1:0][riscv_trace_pkg::Vlen-1:0] pc_head;
  logic [commit_trace_pkg::NrCommitPorts-1:0]                           pc_overflow;

  commit_trace_gen i_commit_trace_gen (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_instr_i ( commit_instr_i ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .trace_o        ( trace_o        ),
    .push_o         ( push           ),
    .push_pc_o      ( push_pc        )
  );

  // one pc queue per commit port
  for (genvar i = 0; i < commit_trace_pkg::NrCommitPorts; i++) begin : gen_pc_queue
    pc_queue i_pc_queue (
      .clk_i      ( clk_i          ),
      .rst_ni     ( rst_ni         ),
      .push_i     ( push[i]        ),
      .pc_i       ( push_pc[i]     ),
      .pop_i      ( pc_pop[i]      ),
      .empty_o    ( pc_empty[i]    ),
      .head_o     ( pc_head[i]     ),
      .overflow_o ( pc_overflow[i] )
    );
  end

  pc_arbiter i_pc_arbiter (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .empty_i        ( pc_empty       ),
    .head_i         ( pc_head        ),
    .pop_o          ( pc_pop         ),
    .retire_valid_o ( retire_valid_o ),
    .retire_o       ( retire_o       )
  );

  // any dropped pc shows up here
  assign overflow_o = |pc_overflow;

endmodule

// ==== tb_commit_trace_unit.sv ====
// Commit trace unit testbench
`timescale 1ns/10ps

module tb_commit_trace_unit;

  localparam int unsigned NrPorts   = commit_trace_pkg::NrCommitPorts;
  localparam int unsigned MaxCycles = 600;

  typedef logic [riscv_trace_pkg::Vlen-1:0] pc_list_t [$];

  logic                                              clk_i;
  logic                                              rst_ni;
  logic [NrPorts-1:0]                                commit_ack_i;
  commit_trace_pkg::commit_entry_t [NrPorts-1:0]     commit_instr_i;
  riscv_trace_pkg::priv_lvl_t                        priv_lvl_i;
  commit_trace_pkg::trace_port_t [NrPorts-1:0]       trace_o;
  logic                                              retire_valid_o;
  commit_trace_pkg::retire_t                         retire_o;
  logic                                              overflow_o;

  // reference state
  pc_list_t                                    exp_pcs [NrPorts];
  commit_trace_pkg::trace_port_t [NrPorts-1:0] exp_trace_q;
  logic [NrPorts-1:0]                          exp_ack_q;
  logic                                        ret_chk_q, ret_hit_q;
  logic [riscv_trace_pkg::Vlen-1:0]            ret_exp_q, ret_got_q;
  logic [commit_trace_pkg::PortIdxWidth-1:0]   ret_port_q;
  logic                                        any_trace_flag;

  // phase flags and bookkeeping
  logic        idle_chk, sparse_chk, relaxed;
  int unsigned cycles;
  int          trace_errs, retire_errs, other_errs;
  int          seed;
  int          wait_cnt;

  commit_trace_unit dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_instr_i ( commit_instr_i ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .trace_o        ( trace_o        ),
    .retire_valid_o ( retire_valid_o ),
    .retire_o       ( retire_o       ),
    .overflow_o     ( overflow_o     )
  );

  always #4 clk_i = ~clk_i;

  // --------------------
  // reference model
  // --------------------

  // record for one port, from the three-case commit rule
  function automatic commit_trace_pkg::trace_port_t expected_trace(
    input logic ack, input commit_trace_pkg::commit_entry_t e,
    input riscv_trace_pkg::priv_lvl_t priv);
    commit_trace_pkg::trace_port_t t;
    logic irq;
    irq         = e.cause[riscv_trace_pkg::IrqCauseBit];
    t.valid     = ack && !e.ex_valid;
    t.exception = ack && e.ex_valid && !irq;
    t.interrupt = ack && e.ex_valid && irq;
    t.iaddr     = e.pc;
    t.insn      = e.tval[riscv_trace_pkg::InsnWidth-1:0];
    t.tval      = e.tval[riscv_trace_pkg::InsnWidth-1:0];
    t.cause     = e.cause;
    t.priv      = priv;
    return t;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin : ref_model
    logic [riscv_trace_pkg::Vlen-1:0] got;
    int unsigned gp;
    logic found;
    if (!rst_ni) begin
      exp_ack_q   <= '0;
      ret_chk_q   <= 1'b0;
      ret_hit_q   <= 1'b0;
      ret_exp_q   <= '0;
      ret_got_q   <= '0;
      ret_port_q  <= '0;
      for (int p = 0; p < NrPorts; p++) begin
        exp_pcs[p].delete();
        // priv keeps following the input through reset
        exp_trace_q[p] <= expected_trace(1'b0, commit_instr_i[p], priv_lvl_i);
      end
    end else begin
      // retire seen now was registered at an earlier edge
      ret_chk_q <= retire_valid_o;
      if (retire_valid_o) begin
        got   = retire_o.pc;
        gp    = retire_o.port;
        found = 1'b0;
        ret_got_q  <= got;
        ret_port_q <= retire_o.port;
        ret_exp_q  <= (exp_pcs[gp].size() > 0) ? exp_pcs[gp][0] : '0;
        if (relaxed) begin
          // dropped entries may be skipped, order must hold
          while (exp_pcs[gp].size() > 0 && !found) begin
            if (exp_pcs[gp][0] == got) begin
              found = 1'b1;
              ret_exp_q <= got;
            end
            void'(exp_pcs[gp].pop_front());
          end
        end else if (exp_pcs[gp].size() > 0) begin
          found = 1'b1;
          void'(exp_pcs[gp].pop_front());
        end
        ret_hit_q <= found;
      end
      for (int p = 0; p < NrPorts; p++) begin
        exp_ack_q[p]   <= commit_ack_i[p];
        exp_trace_q[p] <= expected_trace(commit_ack_i[p], commit_instr_i[p], priv_lvl_i);
        if (commit_ack_i[p] && !commit_instr_i[p].ex_valid) begin
          exp_pcs[p].push_back(commit_instr_i[p].pc);
        end
      end
    end
  end

  always_comb begin
    any_trace_flag = 1'b0;
    for (int p = 0; p < NrPorts; p++) begin
      any_trace_flag |= trace_o[p].valid | trace_o[p].exception | trace_o[p].interrupt;
    end
  end

  // --------------------
  // checks
  // --------------------

  for (genvar p = 0; p < NrPorts; p++) begin : gen_trace_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      exp_ack_q[p] |-> trace_o[p] == exp_trace_q[p])
    else begin
      trace_errs++;
      $display("CHECK FAILED trace_record port %0d: expected %h actual %h", p,
               $sampled(exp_trace_q[p]), $sampled(trace_o[p]));
    end
    // no commit, no record, but priv still follows
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      !exp_ack_q[p] |-> {trace_o[p].valid, trace_o[p].exception, trace_o[p].interrupt,
                         trace_o[p].priv} == {3'b000, exp_trace_q[p].priv})
    else begin
      trace_errs++;
      $display("CHECK FAILED trace_idle port %0d: expected %b actual %b", p,
               {3'b000, $sampled(exp_trace_q[p].priv)},
               {$sampled(trace_o[p].valid), $sampled(trace_o[p].exception),
                $sampled(trace_o[p].interrupt), $sampled(trace_o[p].priv)});
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ret_chk_q |-> ret_hit_q)
  else begin
    retire_errs++;
    $display("retire_o on port %0d gave pc %h, which no pending commit matches",
             $sampled(ret_port_q), $sampled(ret_got_q));
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ret_chk_q && ret_hit_q |-> ret_got_q == ret_exp_q)
  else begin
    retire_errs++;
    $display("CHECK FAILED retire_pc port %0d: expected %h actual %h",
             $sampled(ret_port_q), $sampled(ret_exp_q), $sampled(ret_got_q));
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_chk |-> !any_trace_flag && !retire_valid_o && !overflow_o)
  else begin
    other_errs++;
    $display("outputs active after reset before any commit");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) sparse_chk |-> !overflow_o)
  else begin
    other_errs++;
    $display("overflow_o went high during sparse commits");
  end

  // sticky until reset
  assert property (@(posedge clk_i) disable iff (!rst_ni) overflow_o |=> overflow_o)
  else begin
    other_errs++;
    $display("overflow_o dropped without a reset");
  end

  // --------------------
  // stimulus
  // --------------------

  // kind 0 normal, 1 normal, 2 exception, 3 interrupt
  task automatic drive_port(input int p, input logic ack, input int kind);
    commit_trace_pkg::commit_entry_t e;
    logic [63:0] cause_rnd;
    cause_rnd  = {$random(seed), $random(seed)};
    e.pc       = {$random(seed), $random(seed)};
    e.ex_valid = (kind >= 2);
    e.cause    = {(kind == 3), cause_rnd[riscv_trace_pkg::Xlen-2:0]};
    e.tval     = {$random(seed), $random(seed)};
    commit_ack_i[p]   = ack;
    commit_instr_i[p] = e;
  endtask

  task automatic pick_priv();
    int unsigned r;
    r = $unsigned($random(seed)) % 3;
    priv_lvl_i = (r == 0) ? riscv_trace_pkg::PrivLvlU :
                 (r == 1) ? riscv_trace_pkg::PrivLvlS : riscv_trace_pkg::PrivLvlM;
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout, run did not finish within %0d cycles", MaxCycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int r;
    seed           = 32'h67a0c02c;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    commit_ack_i   = '0;
    commit_instr_i = '0;
    priv_lvl_i     = riscv_trace_pkg::PrivLvlM;
    idle_chk       = 1'b0;
    sparse_chk     = 1'b0;
    relaxed        = 1'b0;
    cycles         = 0;
    trace_errs     = 0;
    retire_errs    = 0;
    other_errs     = 0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    idle_chk = 1'b1;
    repeat (5) @(posedge clk_i);
    #1 idle_chk = 1'b0;

    // sparse, about 0.75 commits per cycle
    sparse_chk = 1'b1;
    repeat (150) begin
      for (int p = 0; p < NrPorts; p++) begin
        r = $random(seed);
        drive_port(p, r[2:0] < 3, int'(r[4:3]));
      end
      pick_priv();
      @(posedge clk_i);
      #1;
    end
    commit_ack_i = '0;
    wait_cnt     = 0;
    while (wait_cnt < 40 && (exp_pcs[0].size() > 0 || exp_pcs[1].size() > 0)) begin
      @(posedge clk_i);
      #1 wait_cnt++;
    end
    assert (exp_pcs[0].size() == 0 && exp_pcs[1].size() == 0)
    else begin
      other_errs++;
      $display("retired PCs still pending 40 cycles after the sparse phase");
    end
    sparse_chk = 1'b0;

    // both ports retire every cycle
    relaxed = 1'b1;
    repeat (60) begin
      for (int p = 0; p < NrPorts; p++) begin
        drive_port(p, 1'b1, 0);
      end
      @(posedge clk_i);
      #1;
    end
    commit_ack_i = '0;
    @(posedge clk_i);
    #1;
    assert (overflow_o)
    else begin
      other_errs++;
      $display("overflow_o never rose during back-to-back commits");
    end
    repeat (40) @(posedge clk_i);
    #1;

    $display("errors: trace %0d, retire %0d, other %0d", trace_errs, retire_errs, other_errs);
    if (trace_errs + retire_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
riscv_trace_pkg.sv
commit_trace_pkg.sv
commit_trace_gen.sv
pc_queue.sv
pc_arbiter.sv
commit_trace_unit.sv
tb_commit_trace_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_commit_trace_unit
FILELIST  := sources.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
